//--- vlog.f
+incdir+hw
hw/pkt_fifo_pkg.sv
hw/pkt_fifo_if.sv
hw/dual_clock_bram.sv
hw/reg_sync.sv
hw/cross_clock_packet_fifo.sv
hw/pkt_framer.sv
hw/pkt_deframer.sv
hw/pkt_fifo_top.sv
dv/pkt_fifo_tb.sv

//--- dv/pkt_fifo_stim.txt
// Columns: expect (1 good, 0 drop, 2 end), tag, header length, payload words sent,
// first payload word; payload word k is the first payload word plus k
1 11 0004 0004 11000000
1 12 0001 0001 12000000
0 a1 0005 0003 a1000000 // Short payload
1 13 0010 0010 13000000
0 a2 0003 0006 a2000000 // Long payload
1 14 0007 0007 14000000
0 a3 0000 0000 a3000000 // Header only, length 0
0 a4 0000 0002 a4000000 // Length 0 with payload
1 15 0020 0020 15000000
1 16 0003 0003 16000000
0 b1 0046 0046 b1000000 // Larger than the memory
1 17 0028 0028 17000000
1 18 0008 0008 18000000
0 a5 0009 0008 a5000000
1 19 000c 000c 19000000
1 1a 0002 0002 1a000000
1 1b 0005 0005 1b000000
2 00 0000 0000 00000000

//--- dv/pkt_fifo_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

module pkt_fifo_tb
	import pkt_fifo_pkg::*;
();

	localparam int RD_HALF    = 4;		// 8 ns read clock
	localparam int WR_HALF    = 6;		// 12 ns write clock
	localparam int STIM_WORDS = 160;	// Up to 32 records of 5 words
	localparam int SLACK      = 40;		// wr_clk periods per stimulus word

	logic                   rd_clk;
	logic                   rd_reset;
	logic                   wr_clk;
	logic                   wr_reset;
	logic                   in_valid;
	logic                   in_first;
	logic                   in_last;
	logic [`PKT_WIDTH-1:0]  in_data;
	logic                   in_drop;
	logic                   out_valid;
	logic                   out_last;
	logic [7:0]             out_tag;
	logic [`PKT_WIDTH-1:0]  out_data;

	logic [31:0]            stim [0:STIM_WORDS-1];	// Raw records from the stim file
	logic [`PKT_WIDTH-1:0]  exp_data [$];			// Payload words still to come out
	logic [7:0]             exp_tag [$];
	logic                   exp_last [$];
	int                     pending_words;			// Same as exp_data size
	int                     errors;
	int                     tests;
	int                     tests_failed;
	int                     drops_expected;
	int                     drops_seen;
	int                     limit_ns;				// Watchdog time, 0 until known
	int                     pkt_words;				// Words of current output packet
	int                     pkt_err_base;			// Error count at its first word
	integer                 seed;

	always #RD_HALF rd_clk = ~rd_clk;
	always #WR_HALF wr_clk = ~wr_clk;

	pkt_fifo_top u_dut (
		.wr_clk    (wr_clk),
		.wr_reset  (wr_reset),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_last   (in_last),
		.in_data   (in_data),
		.in_drop   (in_drop),
		.rd_clk    (rd_clk),
		.rd_reset  (rd_reset),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_tag   (out_tag),
		.out_data  (out_data)
	);

	task automatic check_value(input string name, input logic [31:0] expv,
			input logic [31:0] got);
		assert (got === expv) else begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expv, got);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Write side driver

	task automatic drive_packet(input logic good, input logic [7:0] tag,
			input logic [15:0] len, input int count, input logic [31:0] base);
		pkt_word_u hdr;
		int        err_base;
		int        k;
		hdr.hdr.tag  = tag;
		hdr.hdr.rsvd = 8'h00;
		hdr.hdr.len  = len;
		err_base     = errors;
		if (good) begin		// Expected words queued before any can come out
			for (k = 0; k < count; k++) begin
				exp_data.push_back(base + k);
				exp_tag.push_back(tag);
				exp_last.push_back(k == count - 1);
			end
			pending_words += count;
		end else
			drops_expected++;
		@(negedge wr_clk);
		in_valid = 1'b1;
		in_first = 1'b1;
		in_last  = count == 0;		// Header-only packet
		in_data  = hdr.data;
		for (k = 0; k < count; k++) begin
			@(negedge wr_clk);
			in_first = 1'b0;
			in_last  = k == count - 1;
			in_data  = base + k;
		end
		@(negedge wr_clk);			// in_drop settles one cycle after in_last
		in_valid = 1'b0;
		in_first = 1'b0;
		in_last  = 1'b0;
		check_value("in_drop", {31'd0, !good}, {31'd0, in_drop});
		if (!good) begin
			tests++;
			if (errors != err_base)
				tests_failed++;
			$display("tag %h: dropped, %0d payload words sent, %s", tag, count,
				(errors == err_base) ? "ok" : "FAIL");
		end
	endtask

	always @(negedge wr_clk) begin
		if (!wr_reset && in_drop)
			drops_seen++;		// Compared with drops_expected at the end
	end

	////////////////////////////////////////////////////////////
	// Read side monitor, outputs stable on the falling edge

	always @(negedge rd_clk) begin
		if (!rd_reset && out_valid) begin
			assert (exp_data.size() != 0) else begin
				$display("Word %h with tag %h came out at %0t with no packet expected",
					out_data, out_tag, $time);
				errors++;
			end
			if (exp_data.size() != 0) begin
				if (pkt_words == 0)
					pkt_err_base = errors;
				check_value("out_data", exp_data[0], out_data);
				check_value("out_tag", exp_tag[0], out_tag);
				check_value("out_last", exp_last[0], out_last);
				pkt_words++;
				if (exp_last[0]) begin		// Packet finished
					tests++;
					if (errors != pkt_err_base)
						tests_failed++;
					$display("tag %h: %0d payload words received, %s", exp_tag[0],
						pkt_words, (errors == pkt_err_base) ? "ok" : "FAIL");
					pkt_words = 0;
				end
				exp_data.pop_front();
				exp_tag.pop_front();
				exp_last.pop_front();
				pending_words--;
			end
		end else if (!rd_reset) begin
			assert (!out_last) else begin
				$display("out_last high without out_valid at %0t", $time);
				errors++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Watchdog

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("Run timed out after %0d ns, %0d payload words never came out",
			limit_ns, pending_words);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int idx;
		int nrec;
		int stim_total;
		int gap;
		rd_clk         = 1'b0;
		wr_clk         = 1'b0;
		rd_reset       = 1'b1;
		wr_reset       = 1'b1;
		in_valid       = 1'b0;
		in_first       = 1'b0;
		in_last        = 1'b0;
		in_data        = '0;
		errors         = 0;
		tests          = 0;
		tests_failed   = 0;
		drops_expected = 0;
		drops_seen     = 0;
		pending_words  = 0;
		pkt_words      = 0;
		pkt_err_base   = 0;
		limit_ns       = 0;
		seed           = 32'hf16b_9b14;
		$readmemh("dv/pkt_fifo_stim.txt", stim);
		nrec       = 0;
		stim_total = 0;
		while (nrec < STIM_WORDS / 5 &&
				(stim[5*nrec] === 32'd0 || stim[5*nrec] === 32'd1)) begin
			stim_total += stim[5*nrec+3] + 1;	// Header plus payload
			nrec++;
		end
		limit_ns = stim_total * SLACK * 2 * WR_HALF + 2000;
		assert (nrec != 0) else begin
			$display("Stimulus file holds no packet records");
			errors++;
		end
		fork
			begin
				repeat (8) @(negedge rd_clk);
				rd_reset = 1'b0;
			end
			begin
				repeat (8) @(negedge wr_clk);
				wr_reset = 1'b0;
			end
		join
		for (idx = 0; idx < nrec; idx++) begin
			// Oversize packet needs an empty FIFO, so drain it first
			if (stim[5*idx+3] >= `PKT_DEPTH - 1)
				while (pending_words != 0)
					@(negedge wr_clk);
			drive_packet(stim[5*idx] == 32'd1, stim[5*idx+1][7:0], stim[5*idx+2][15:0],
				stim[5*idx+3], stim[5*idx+4]);
			gap = $unsigned($random(seed)) % 8;	// Idle cycles between packets
			repeat (gap) @(negedge wr_clk);
		end
		while (pending_words != 0)
			@(negedge rd_clk);
		repeat (50) @(negedge rd_clk);		// Room for stray output words
		check_value("drop count", drops_expected, drops_seen);
		$display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/pkt_fifo_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

module pkt_fifo_top (
	// Write domain
	input  logic                   wr_clk,
	input  logic                   wr_reset,
	input  logic                   in_valid,
	input  logic                   in_first,
	input  logic                   in_last,
	input  logic [`PKT_WIDTH-1:0]  in_data,
	output logic                   in_drop,

	// Read domain
	input  logic                   rd_clk,
	input  logic                   rd_reset,
	output logic                   out_valid,
	output logic                   out_last,
	output logic [7:0]             out_tag,
	output logic [`PKT_WIDTH-1:0]  out_data
);

	pkt_wr_if wr_bus ();	// Framer to FIFO
	pkt_rd_if rd_bus ();	// FIFO to deframer

	pkt_framer u_framer (
		.wr_clk   (wr_clk),
		.wr_reset (wr_reset),
		.in_valid (in_valid),
		.in_first (in_first),
		.in_last  (in_last),
		.in_data  (in_data),
		.in_drop  (in_drop),
		.wr       (wr_bus.framer)
	);

	cross_clock_packet_fifo u_fifo (
		.wr_clk   (wr_clk),
		.wr_reset (wr_reset),
		.rd_clk   (rd_clk),
		.rd_reset (rd_reset),
		.wr       (wr_bus.fifo),
		.rd       (rd_bus.fifo)
	);

	pkt_deframer u_deframer (
		.rd_clk    (rd_clk),
		.rd_reset  (rd_reset),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_tag   (out_tag),
		.out_data  (out_data),
		.rd        (rd_bus.deframer)
	);

endmodule

`default_nettype wire

//--- hw/pkt_deframer.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

module pkt_deframer
	import pkt_fifo_pkg::*;
(
	input  logic                   rd_clk,
	input  logic                   rd_reset,
	output logic                   out_valid,
	output logic                   out_last,
	output logic [7:0]             out_tag,		// Held for the whole packet
	output logic [`PKT_WIDTH-1:0]  out_data,
	pkt_rd_if.deframer             rd
);

	typedef enum logic [2:0] {
		ST_IDLE,		// Wait for a committed packet
		ST_HEADER,		// Read offset 0
		ST_DECODE,		// Header on rd_data
		ST_STREAM,		// One payload request per cycle
		ST_POP			// Pop, then one idle cycle
	} state_t;

	state_t                     state;
	pkt_word_u                  rd_word;
	logic [`PKT_ADDR_BITS-1:0]  idx;		// Next payload offset
	logic [`PKT_ADDR_BITS-1:0]  len_q;		// Payload length, fits since packet fit memory
	logic                       pop_wait;
	logic                       req_last;

	assign rd_word  = rd.rd_data;
	assign out_data = rd_word.data;		// Registered in the memory already
	assign req_last = idx == len_q;

	assign rd.rd_en          = (state == ST_HEADER) || (state == ST_STREAM);
	assign rd.rd_offset      = (state == ST_STREAM) ? idx : '0;
	assign rd.rd_pop_packet  = (state == ST_POP) && !pop_wait;
	assign rd.rd_packet_size = {1'b0, len_q} + 1'b1;	// Header plus payload

	////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			state     <= ST_IDLE;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			pop_wait  <= 1'b0;
			idx       <= '0;
		end else begin
			out_valid <= state == ST_STREAM;	// Lines up with read latency
			out_last  <= (state == ST_STREAM) && req_last;
			case (state)
				ST_IDLE: begin
					if (rd.rd_size != '0)
						state <= ST_HEADER;
				end
				ST_HEADER: state <= ST_DECODE;
				ST_DECODE: begin
					idx   <= 1;		// First payload word
					state <= ST_STREAM;
				end
				ST_STREAM: begin
					idx <= idx + 1'b1;
					if (req_last)
						state <= ST_POP;
				end
				ST_POP: begin
					pop_wait <= !pop_wait;	// Second cycle lets rd_size settle
					if (pop_wait)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Header fields
	always_ff @(posedge rd_clk) begin
		if (state == ST_DECODE) begin
			out_tag <= rd_word.hdr.tag;
			len_q   <= rd_word.hdr.len[`PKT_ADDR_BITS-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/pkt_framer.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

module pkt_framer
	import pkt_fifo_pkg::*;
(
	input  logic                   wr_clk,
	input  logic                   wr_reset,
	input  logic                   in_valid,
	input  logic                   in_first,	// Header word
	input  logic                   in_last,		// Final word of packet
	input  logic [`PKT_WIDTH-1:0]  in_data,
	output logic                   in_drop,		// Packet rolled back
	pkt_wr_if.framer               wr
);

	pkt_word_u    in_word;
	logic         in_pkt;		// Inside a packet after its header
	logic [15:0]  exp_len;		// Length from header
	logic [15:0]  count;		// Payload words seen
	logic         ovf;			// Sticky, some word could not be written
	logic         take;
	logic         blocked;
	logic         ovf_next;
	logic [15:0]  cnt_next;
	logic [15:0]  len_cur;
	logic         pkt_end;
	logic         pkt_good;

	assign in_word = in_data;
	assign take    = in_valid && (in_first || in_pkt);	// Word belongs to a packet

	// No room, or a rollback in this cycle would swallow the write
	assign blocked  = (wr.wr_size == '0) || wr.wr_rollback;
	assign ovf_next = (ovf && !in_first) || blocked;

	assign wr.wr_en   = take && !blocked && !(ovf && !in_first);
	assign wr.wr_data = in_word.data;

	////////////////////////////////////////////////////////////
	// Length check, header word itself not counted

	assign cnt_next = in_first ? 16'd0 : count + 16'd1;
	assign len_cur  = in_first ? in_word.hdr.len : exp_len;
	assign pkt_end  = take && in_last;
	assign pkt_good = (cnt_next == len_cur) && (len_cur != 16'd0) && !ovf_next;

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			in_pkt         <= 1'b0;
			ovf            <= 1'b0;
			count          <= 16'd0;
			wr.wr_commit   <= 1'b0;
			wr.wr_rollback <= 1'b0;
			in_drop        <= 1'b0;
		end else begin
			wr.wr_commit   <= pkt_end && pkt_good;	// Cycle after in_last
			wr.wr_rollback <= pkt_end && !pkt_good;
			in_drop        <= pkt_end && !pkt_good;
			if (take) begin
				in_pkt <= !in_last;
				ovf    <= ovf_next;
				count  <= cnt_next;
			end
		end
	end

	always_ff @(posedge wr_clk) begin
		if (take && in_first)
			exp_len <= in_word.hdr.len;
	end

endmodule

`default_nettype wire

//--- hw/cross_clock_packet_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

module cross_clock_packet_fifo
	import pkt_fifo_pkg::*;
(
	input  logic     wr_clk,
	input  logic     wr_reset,
	input  logic     rd_clk,
	input  logic     rd_reset,
	pkt_wr_if.fifo   wr,
	pkt_rd_if.fifo   rd
);

	pkt_ptr_t  wptr;			// Next write slot, extra bit for full/empty
	pkt_ptr_t  wptr_commit;		// End of last committed packet
	pkt_ptr_t  rptr;			// Start of oldest packet
	pkt_ptr_t  tail;			// wptr_commit seen on rd_clk
	pkt_ptr_t  head;			// rptr seen on wr_clk
	logic      rptr_updated;
	logic [`PKT_ADDR_BITS-1:0] rd_addr;

	assign rd_addr = rptr[`PKT_ADDR_BITS-1:0] + rd.rd_offset;	// Wraps in memory

	////////////////////////////////////////////////////////////
	// Storage

	dual_clock_bram #(
		.WIDTH     (`PKT_WIDTH),
		.ADDR_BITS (`PKT_ADDR_BITS)
	) u_mem (
		.wr_clk  (wr_clk),
		.wr_en   (wr.wr_en),
		.wr_addr (wptr[`PKT_ADDR_BITS-1:0]),
		.wr_data (wr.wr_data),
		.rd_clk  (rd_clk),
		.rd_en   (rd.rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd.rd_data)
	);

	////////////////////////////////////////////////////////////
	// Write domain

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wptr        <= '0;
			wptr_commit <= '0;
		end else begin
			if (wr.wr_en)
				wptr <= wptr + 1'b1;
			if (wr.wr_commit)
				wptr_commit <= wptr;
			if (wr.wr_rollback)
				wptr <= wptr_commit;	// Wins over a write in the same cycle
		end
	end

	assign wr.wr_size = pkt_ptr_t'(`PKT_DEPTH) + head - wptr;

	////////////////////////////////////////////////////////////
	// Read domain

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rptr         <= '0;
			rptr_updated <= 1'b0;
		end else begin
			rptr_updated <= rd.rd_pop_packet;
			if (rd.rd_pop_packet)
				rptr <= rptr + rd.rd_packet_size;	// Whole packet at once
		end
	end

	assign rd.rd_size = tail - rptr;

	// Committed end of data, toward the reader
	reg_sync #(.WIDTH(`PKT_ADDR_BITS+1)) u_sync_tail (
		.clk_a     (wr_clk),
		.reset_a   (wr_reset),
		.en_a      (wr.wr_commit),
		.reg_a     (wptr),
		.clk_b     (rd_clk),
		.reset_b   (rd_reset),
		.reg_b     (tail),
		.updated_b ()
	);

	// Freed space, back toward the writer
	reg_sync #(.WIDTH(`PKT_ADDR_BITS+1)) u_sync_head (
		.clk_a     (rd_clk),
		.reset_a   (rd_reset),
		.en_a      (rptr_updated),
		.reg_a     (rptr),
		.clk_b     (wr_clk),
		.reset_b   (wr_reset),
		.reg_b     (head),
		.updated_b ()
	);

endmodule

`default_nettype wire

//--- hw/reg_sync.sv
`timescale 1ns/10ps
`default_nettype none

module reg_sync #(
	parameter int WIDTH = 8
)(
	input  logic              clk_a,
	input  logic              reset_a,
	input  logic              en_a,		// Send reg_a
	input  logic [WIDTH-1:0]  reg_a,

	input  logic              clk_b,
	input  logic              reset_b,
	output logic [WIDTH-1:0]  reg_b,		// Last value received
	output logic              updated_b	// One cycle when reg_b loads
);

	logic [WIDTH-1:0]  hold_a;		// Newest value waiting to go
	logic [WIDTH-1:0]  tx_a;		// Value in flight, stable while busy
	logic              pending_a;
	logic              req_a;		// Request toggle
	logic [1:0]        ack_sync_a;	// Acknowledge toggle, two flops
	logic              busy_a;
	logic [2:0]        req_sync_b;	// Two sync flops plus edge detect
	logic              new_b;

	assign busy_a = req_a != ack_sync_a[1];
	assign new_b  = req_sync_b[2] != req_sync_b[1];

	////////////////////////////////////////////////////////////
	// Domain a

	always_ff @(posedge clk_a) begin
		if (reset_a) begin
			pending_a  <= 1'b0;
			req_a      <= 1'b0;
			ack_sync_a <= 2'b00;
		end else begin
			ack_sync_a <= {ack_sync_a[0], req_sync_b[2]};
			if (pending_a && !busy_a)
				req_a <= ~req_a;		// Launch held value
			if (en_a)
				pending_a <= 1'b1;		// Newer value replaces older one
			else if (!busy_a)
				pending_a <= 1'b0;
		end
	end

	always_ff @(posedge clk_a) begin
		if (pending_a && !busy_a)
			tx_a <= hold_a;
		if (en_a)
			hold_a <= reg_a;
	end

	////////////////////////////////////////////////////////////
	// Domain b

	always_ff @(posedge clk_b) begin
		if (reset_b) begin
			req_sync_b <= 3'b000;
			reg_b      <= '0;
			updated_b  <= 1'b0;
		end else begin
			req_sync_b <= {req_sync_b[1:0], req_a};
			updated_b  <= new_b;
			if (new_b)
				reg_b <= tx_a;				// tx_a settled two cycles ago
		end
	end

endmodule

`default_nettype wire

//--- hw/dual_clock_bram.sv
`timescale 1ns/10ps
`default_nettype none

module dual_clock_bram #(
	parameter int WIDTH     = 32,
	parameter int ADDR_BITS = 6
)(
	// Write side
	input  logic                  wr_clk,
	input  logic                  wr_en,
	input  logic [ADDR_BITS-1:0]  wr_addr,
	input  logic [WIDTH-1:0]      wr_data,

	// Read side, one cycle latency
	input  logic                  rd_clk,
	input  logic                  rd_en,
	input  logic [ADDR_BITS-1:0]  rd_addr,
	output logic [WIDTH-1:0]      rd_data
);

	logic [WIDTH-1:0] mem [0:(1 << ADDR_BITS)-1];	// Storage array

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Output register holds last word while idle
	always_ff @(posedge rd_clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/pkt_fifo_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "pkt_fifo_macros.svh"

////////////////////////////////////////////////////////////
// Write port, all signals on wr_clk

interface pkt_wr_if;
	logic                     wr_en;		// Push one word
	logic [`PKT_WIDTH-1:0]    wr_data;
	logic                     wr_commit;	// Make all pushed words readable
	logic                     wr_rollback;	// Discard words since last commit
	logic [`PKT_ADDR_BITS:0]  wr_size;		// Free words, uncommitted ones count as used

	modport framer (
		output wr_en, wr_data, wr_commit, wr_rollback,
		input  wr_size
	);

	modport fifo (
		input  wr_en, wr_data, wr_commit, wr_rollback,
		output wr_size
	);
endinterface

////////////////////////////////////////////////////////////
// Read port, all signals on rd_clk

interface pkt_rd_if;
	logic                       rd_en;			// Data comes one cycle later
	logic [`PKT_ADDR_BITS-1:0]  rd_offset;		// Offset from current packet start
	logic                       rd_pop_packet;	// Drop rd_packet_size words
	logic [`PKT_ADDR_BITS:0]    rd_packet_size;
	logic [`PKT_WIDTH-1:0]      rd_data;
	logic [`PKT_ADDR_BITS:0]    rd_size;		// Committed words visible here

	modport deframer (
		output rd_en, rd_offset, rd_pop_packet, rd_packet_size,
		input  rd_data, rd_size
	);

	modport fifo (
		input  rd_en, rd_offset, rd_pop_packet, rd_packet_size,
		output rd_data, rd_size
	);
endinterface

`default_nettype wire

//--- hw/pkt_fifo_pkg.sv
`default_nettype none
`include "pkt_fifo_macros.svh"

package pkt_fifo_pkg;

	// Pointer or size value, one bit wider than a memory address
	typedef logic [`PKT_ADDR_BITS:0] pkt_ptr_t;

	// Header word layout
	typedef struct packed {
		logic [7:0]  tag;	// Packet tag, passed to the sink
		logic [7:0]  rsvd;	// Unused
		logic [15:0] len;	// Payload words after the header, 0 is illegal
	} pkt_hdr_t;

	// Same storage word seen as header or as payload
	typedef union packed {
		pkt_hdr_t               hdr;
		logic [`PKT_WIDTH-1:0]  data;
	} pkt_word_u;

endpackage

`default_nettype wire

//--- hw/pkt_fifo_macros.svh
`ifndef PKT_FIFO_MACROS_SVH
`define PKT_FIFO_MACROS_SVH

// Width of one stored word
`define PKT_WIDTH 32

// Number of words in the packet memory
`define PKT_DEPTH 64

// Address bits for PKT_DEPTH words, pointers carry one extra bit
`define PKT_ADDR_BITS 6

`endif
